// ==== common/memPkg.sv ====
package memPkg;

    // structs carry the widest address, modules truncate to their ADDR_W
    localparam int MAX_ADDR_W = 32;

    typedef enum logic {
        opLoad,
        opStore
    } accessOp_e;

    // 2'b11 is not a legal size
    typedef enum logic [1:0] {
        lenByte,
        lenHalf,
        lenWord
    } accessLen_e;

    typedef enum logic [1:0] {
        sIdle,
        sFetch,
        sLoad,
        sStore
    } seqState_e;

    typedef enum logic [1:0] {
        srcNone,
        srcFetch,
        srcData
    } reqSrc_e;

    typedef struct packed {
        accessOp_e              op;
        accessLen_e             len;
        logic [MAX_ADDR_W-1:0]  addr;
        logic [31:0]            wdata;
    } dataReq_t;

    // fetches ride along as word loads tagged srcFetch
    typedef struct packed {
        reqSrc_e                src;
        accessOp_e              op;
        accessLen_e             len;
        logic [MAX_ADDR_W-1:0]  addr;
        logic [31:0]            wdata;
    } memReq_t;

    typedef struct packed {
        logic                   en;
        logic                   we;
        logic [MAX_ADDR_W-1:0]  addr;
        logic [7:0]             wdata;
    } ramCmd_t;

    function automatic logic [2:0] lenToBytes(input accessLen_e len);
        case (len)
            lenByte: lenToBytes = 3'd1;
            lenHalf: lenToBytes = 3'd2;
            default: lenToBytes = 3'd4;
        endcase
    endfunction

endpackage

// ==== src/reqArbiter.sv ====
`timescale 1ns/1ps

module reqArbiter
    import memPkg::*;
#(
    parameter int ADDR_W = 17
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              fetchReq,
    input  logic [ADDR_W-1:0] fetchAddr,
    input  logic              dataReq,
    input  dataReq_t          dataIn,
    input  logic              seqIdle,
    output logic              grant,
    output memReq_t           grantReq
);

    logic              fetchPend;
    logic [ADDR_W-1:0] fetchAddrQ;
    logic              dataPend;
    dataReq_t          dataQ;
    logic              pickData;

    // data always goes first
    assign pickData = dataPend;
    assign grant    = seqIdle && (fetchPend || dataPend);

    always_comb begin
        if (pickData) begin
            grantReq.src   = srcData;
            grantReq.op    = dataQ.op;
            grantReq.len   = dataQ.len;
            grantReq.addr  = dataQ.addr;
            grantReq.wdata = dataQ.wdata;
        end else begin
            grantReq.src   = fetchPend ? srcFetch : srcNone;
            grantReq.op    = opLoad;
            grantReq.len   = lenWord;
            grantReq.addr  = MAX_ADDR_W'(fetchAddrQ);
            grantReq.wdata = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            fetchPend <= 1'b0;
            dataPend  <= 1'b0;
        end else begin
            // clear on grant first so a new strobe still lands
            if (grant && pickData) begin
                dataPend <= 1'b0;
            end
            if (grant && !pickData) begin
                fetchPend <= 1'b0;
            end
            if (fetchReq) begin
                fetchPend <= 1'b1;
            end
            if (dataReq) begin
                dataPend <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetchReq) begin
            fetchAddrQ <= fetchAddr;
        end
        if (dataReq) begin
            dataQ      <= dataIn;
            dataQ.addr <= MAX_ADDR_W'(dataIn.addr[ADDR_W-1:0]);
        end
    end

    // a client must wait for its done pulse before strobing again
    assert property (@(posedge clk) disable iff (rst) fetchReq |-> !fetchPend)
        else $error("fetch strobe into an occupied slot");

    assert property (@(posedge clk) disable iff (rst) dataReq |-> !dataPend)
        else $error("data strobe into an occupied slot");

    assert property (@(posedge clk) disable iff (rst)
        dataReq |-> dataIn.len inside {lenByte, lenHalf, lenWord})
        else $error("illegal access length on data request");

endmodule

// ==== memCtrl/memCtrl.sv ====
`timescale 1ns/1ps

module memCtrl
    import memPkg::*;
#(
    parameter int ADDR_W = 17
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        ioBufferFull,
    input  logic        grant,
    input  memReq_t     grantReq,
    output logic        seqIdle,
    output reqSrc_e     owner,
    output ramCmd_t     ramCmd,
    input  logic [7:0]  ramRdata,
    output logic        fetchDone,
    output logic [31:0] fetchInst,
    output logic        dataDone,
    output logic [31:0] dataOut
);

    seqState_e         state;
    memReq_t           req;
    logic [2:0]        idx;
    logic [1:0]        capIdx;
    logic              rdPend;
    logic [31:0]       asmWord;
    logic [31:0]       readWord;
    logic [2:0]        nBytes;
    logic [ADDR_W-1:0] byteAddr;
    logic              isRead;
    logic              issue;
    logic              readDone;
    logic              storeDone;

    assign seqIdle  = (state == sIdle);
    assign isRead   = (state == sFetch) || (state == sLoad);
    assign nBytes   = lenToBytes(req.len);
    assign byteAddr = req.addr[ADDR_W-1:0] + ADDR_W'(idx);

    // one byte per unstalled cycle until all are out
    assign issue = !seqIdle && !ioBufferFull && (idx < nBytes);

    assign readDone  = isRead && !ioBufferFull && rdPend && (idx == nBytes);
    assign storeDone = (state == sStore) && !ioBufferFull && (idx == nBytes - 3'd1);

    always_comb begin
        ramCmd.en    = issue;
        ramCmd.we    = (state == sStore);
        ramCmd.addr  = MAX_ADDR_W'(byteAddr);
        ramCmd.wdata = req.wdata[{idx[1:0], 3'b000} +: 8];
    end

    // last byte comes straight from the RAM, lanes past the length are zeroed
    always_comb begin
        readWord = asmWord;
        readWord[{capIdx, 3'b000} +: 8] = ramRdata;
        for (int b = 0; b < 4; b++) begin
            if (3'(b) >= nBytes) begin
                readWord[b*8 +: 8] = 8'h00;
            end
        end
    end

    assign fetchDone = readDone && (state == sFetch);
    assign dataDone  = (readDone && (state == sLoad)) || storeDone;
    assign fetchInst = readWord;
    assign dataOut   = readWord;

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= sIdle;
            owner  <= srcNone;
            idx    <= 3'd0;
            rdPend <= 1'b0;
        end else begin
            case (state)
                sIdle: begin
                    if (grant) begin
                        owner  <= grantReq.src;
                        idx    <= 3'd0;
                        rdPend <= 1'b0;
                        if (grantReq.src == srcFetch) begin
                            state <= sFetch;
                        end else if (grantReq.op == opStore) begin
                            state <= sStore;
                        end else begin
                            state <= sLoad;
                        end
                    end
                end
                sFetch, sLoad: begin
                    if (ioBufferFull) begin
                        // frozen read is dropped and asked for again
                        if (rdPend) begin
                            idx    <= {1'b0, capIdx};
                            rdPend <= 1'b0;
                        end
                    end else if (readDone) begin
                        state  <= sIdle;
                        owner  <= srcNone;
                        rdPend <= 1'b0;
                    end else begin
                        idx    <= idx + 3'd1;
                        rdPend <= issue;
                    end
                end
                sStore: begin
                    if (!ioBufferFull) begin
                        if (storeDone) begin
                            state <= sIdle;
                            owner <= srcNone;
                        end else begin
                            idx <= idx + 3'd1;
                        end
                    end
                end
                default: begin
                    state <= sIdle;
                    owner <= srcNone;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (seqIdle && grant) begin
            req <= grantReq;
        end
        if (issue) begin
            capIdx <= idx[1:0];
        end
        if (isRead && !ioBufferFull && rdPend) begin
            asmWord[{capIdx, 3'b000} +: 8] <= ramRdata;
        end
    end

    // every completion hands the sequencer back
    assert property (@(posedge clk) disable iff (rst) (fetchDone || dataDone) |=> seqIdle)
        else $error("sequencer not idle after a done pulse");

    // a stall freezes a busy sequencer in place
    assert property (@(posedge clk) disable iff (rst)
        ioBufferFull && !seqIdle |=> $stable(state))
        else $error("sequencer state moved during stall");

endmodule

// ==== src/byteRam.sv ====
`timescale 1ns/1ps

module byteRam
    import memPkg::*;
#(
    parameter int ADDR_W = 17
) (
    input  logic       clk,
    input  ramCmd_t    ramCmd,
    output logic [7:0] ramRdata
);

    localparam int RAM_DEPTH = 1 << ADDR_W;

    logic [7:0]        mem [RAM_DEPTH];
    logic [ADDR_W-1:0] ramAddr;

    assign ramAddr = ramCmd.addr[ADDR_W-1:0];

    // board memory powers up cleared
    initial begin
        for (int i = 0; i < RAM_DEPTH; i++) begin
            mem[i] = 8'h00;
        end
    end

    // read data shows up the cycle after the request and then holds
    always_ff @(posedge clk) begin
        if (ramCmd.en) begin
            if (ramCmd.we) begin
                mem[ramAddr] <= ramCmd.wdata;
            end else begin
                ramRdata <= mem[ramAddr];
            end
        end
    end

endmodule

// ==== src/memSubsystem.sv ====
`timescale 1ns/1ps

module memSubsystem
    import memPkg::*;
#(
    parameter int ADDR_W = 17
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              fetchReq,
    input  logic [ADDR_W-1:0] fetchAddr,
    output logic              fetchDone,
    output logic [31:0]       fetchInst,
    input  logic              dataReq,
    input  dataReq_t          dataIn,
    output logic              dataDone,
    output logic [31:0]       dataOut,
    input  logic              ioBufferFull,
    output reqSrc_e           owner
);

    logic       grant;
    memReq_t    grantReq;
    logic       seqIdle;
    ramCmd_t    ramCmd;
    logic [7:0] ramRdata;

    reqArbiter #(.ADDR_W(ADDR_W)) arbiter (
        .clk       (clk),
        .rst       (rst),
        .fetchReq  (fetchReq),
        .fetchAddr (fetchAddr),
        .dataReq   (dataReq),
        .dataIn    (dataIn),
        .seqIdle   (seqIdle),
        .grant     (grant),
        .grantReq  (grantReq)
    );

    memCtrl #(.ADDR_W(ADDR_W)) sequencer (
        .clk          (clk),
        .rst          (rst),
        .ioBufferFull (ioBufferFull),
        .grant        (grant),
        .grantReq     (grantReq),
        .seqIdle      (seqIdle),
        .owner        (owner),
        .ramCmd       (ramCmd),
        .ramRdata     (ramRdata),
        .fetchDone    (fetchDone),
        .fetchInst    (fetchInst),
        .dataDone     (dataDone),
        .dataOut      (dataOut)
    );

    byteRam #(.ADDR_W(ADDR_W)) ram (
        .clk      (clk),
        .ramCmd   (ramCmd),
        .ramRdata (ramRdata)
    );

endmodule

// ==== tb/memChecker.sv ====
`timescale 1ns/1ps

module memChecker
    import memPkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        fetchReq,
    input  logic        dataReq,
    input  logic        fetchDone,
    input  logic        dataDone,
    input  logic [31:0] fetchInst,
    input  logic [31:0] dataOut,
    input  logic        ioBufferFull,
    input  reqSrc_e     owner,
    input  logic        fetchBusy,
    input  logic        dataBusy,
    input  logic        dataIsStore,
    input  logic [31:0] expFetch,
    input  logic [31:0] expData,
    input  int          latTarget,
    input  logic        orderCheck,
    input  int          testId,
    input  logic        finished,
    output int          errCount
);

    int   checkCount, reqCount, doneCount, testErrs, curTest, cycle, strobeCyc;
    logic closed;

    function automatic string testName(input int id);
        case (id)
            1: return "reset and latency";
            2: return "store then load";
            3: return "fetch";
            4: return "contention";
            5: return "stall";
            default: return "random traffic";
        endcase
    endfunction

    task automatic noteError();
        errCount++;
        testErrs++;
    endtask

    task automatic reportTest();
        if (curTest != 0 && testErrs == 0) begin
            $display("test %0d %s: ok", curTest, testName(curTest));
        end else if (curTest != 0) begin
            $display("test %0d %s: %0d errors", curTest, testName(curTest), testErrs);
        end
    endtask

    // sampled mid-cycle, where ports and expectations are settled
    always @(negedge clk) begin
        if (rst) begin
            {errCount, checkCount, reqCount, doneCount, testErrs, curTest, cycle} = '0;
            strobeCyc = 0;
            closed = 1'b0;
        end else begin
            cycle++;
            if (testId != curTest) begin
                reportTest();
                curTest = testId;
                testErrs = 0;
            end
            reqCount += int'(fetchReq) + int'(dataReq);
            if (dataReq) begin
                strobeCyc = cycle;
            end
            if (fetchDone) begin
                doneCount++;
                checkCount++;
                if (!fetchBusy) begin
                    $display("fetch done pulse with no fetch outstanding at %0t", $time);
                    noteError();
                end else if (fetchInst !== expFetch) begin
                    $display("Fail at %0t: fetchInst %h, expected %h", $time, fetchInst, expFetch);
                    noteError();
                end
                if (owner != srcFetch) begin
                    $display("Fail at %0t: owner %0d at fetch done, expected srcFetch",
                             $time, owner);
                    noteError();
                end
                if (orderCheck && dataBusy) begin
                    $display("fetch finished ahead of the data access at %0t", $time);
                    noteError();
                end
            end
            if (dataDone) begin
                doneCount++;
                checkCount++;
                if (!dataBusy) begin
                    $display("data done pulse with no data access outstanding at %0t", $time);
                    noteError();
                end else if (!dataIsStore && dataOut !== expData) begin
                    $display("Fail at %0t: dataOut %h, expected %h", $time, dataOut, expData);
                    noteError();
                end
                if (owner != srcData) begin
                    $display("Fail at %0t: owner %0d at data done, expected srcData",
                             $time, owner);
                    noteError();
                end
                if (latTarget != 0 && cycle - strobeCyc != latTarget) begin
                    $display("Fail at %0t: data done after %0d cycles, expected %0d",
                             $time, cycle - strobeCyc, latTarget);
                    noteError();
                end
            end
            if ((fetchDone || dataDone) && ioBufferFull) begin
                $display("done pulse while ioBufferFull was high at %0t", $time);
                noteError();
            end
            if (!fetchBusy && !dataBusy && owner != srcNone) begin
                $display("owner not srcNone with nothing outstanding at %0t", $time);
                noteError();
            end
            if (finished && !closed) begin
                reportTest();
                if (reqCount != doneCount) begin
                    $display("request count and done pulse count differ");
                    noteError();
                end
                $display("closing counts: %0d checks, %0d errors, %0d requests, %0d done pulses",
                         checkCount, errCount, reqCount, doneCount);
                closed = 1'b1;
            end
        end
    end

endmodule

// ==== tb/tbMemSubsystem.sv ====
`timescale 1ns/1ps

module tbMemSubsystem
    import memPkg::*;
();

    localparam int ADDR_W = 17;
    localparam int RAND_REQ = 400;
    localparam int STALL_REQ = 60;
    localparam int TOTAL_REQ = RAND_REQ + STALL_REQ + 64;
    localparam int CYCLES_PER_REQ = 32;
    localparam int CYCLE_LIMIT = (TOTAL_REQ + STALL_REQ) * CYCLES_PER_REQ + 500;
    localparam logic [31:0] WIN_BASE = 32'h0000_0100;
    localparam logic [31:0] ZERO_BASE = 32'h0001_8000;

    logic clk = 1'b0;
    logic rst, fetchReq, fetchDone, dataReq, dataDone, ioBufferFull;
    logic [ADDR_W-1:0] fetchAddr;
    logic [31:0] fetchInst, dataOut, expFetch, expData, lfsr;
    dataReq_t dataIn, pendStore;
    reqSrc_e owner;
    logic fetchBusy, dataBusy, dataIsStore, orderCheck, finished, stallEnable;
    int latTarget, testId, errCount, stallLeft;
    int cycleCount = 0;
    logic [7:0] model [1 << ADDR_W];

    memSubsystem #(.ADDR_W(ADDR_W)) uut (.*);

    memChecker memChecker (.*);

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CYCLE_LIMIT) begin
            $display("run timed out with requests outstanding");
            $display("tests failed");
            $finish;
        end
    end

    // Galois form, taps 32 30 26 25
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
    endfunction

    task automatic takeBits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsrNext(lfsr);
        end
    endtask

    function automatic int sizeOf(input accessLen_e len);
        return (len == lenByte) ? 1 : (len == lenHalf) ? 2 : 4;
    endfunction

    function automatic logic [31:0] modelRead(input logic [31:0] addr, input int n);
        logic [31:0] w;
        w = '0;
        for (int b = 0; b < n; b++) begin
            w[b*8 +: 8] = model[ADDR_W'(addr + 32'(b))];
        end
        return w;
    endfunction

    task automatic issueData(input accessOp_e op, input accessLen_e len,
                             input logic [31:0] addr, input logic [31:0] wdata);
        dataIn = '{op: op, len: len, addr: addr, wdata: wdata};
        dataReq = 1'b1;
        dataBusy = 1'b1;
        dataIsStore = (op == opStore);
        if (op == opStore) begin
            pendStore = dataIn;
        end else begin
            expData = modelRead(addr, sizeOf(len));
        end
    endtask

    task automatic issueFetch(input logic [31:0] addr);
        fetchAddr = ADDR_W'(addr);
        fetchReq = 1'b1;
        fetchBusy = 1'b1;
        expFetch = modelRead(addr, 4);
    endtask

    // done is sampled mid-cycle, inputs change 1 ns past the edge
    task automatic tick();
        logic fd;
        logic dd;
        logic [31:0] r;
        @(negedge clk);
        fd = fetchDone;
        dd = dataDone;
        @(posedge clk);
        #1;
        fetchReq = 1'b0;
        dataReq = 1'b0;
        if (fd) begin
            fetchBusy = 1'b0;
        end
        if (dd) begin
            dataBusy = 1'b0;
            for (int b = 0; b < sizeOf(pendStore.len) && dataIsStore; b++) begin
                model[ADDR_W'(pendStore.addr + 32'(b))] = pendStore.wdata[b*8 +: 8];
            end
        end
        ioBufferFull = 1'b0;
        if (stallLeft > 0) begin
            ioBufferFull = 1'b1;
            stallLeft--;
        end else if (stallEnable) begin
            takeBits(3, r);
            if (r == 0) begin
                takeBits(3, r);
                stallLeft = int'(r);
                ioBufferFull = 1'b1;
            end
        end
    endtask

    task automatic waitIdle();
        while (fetchBusy || dataBusy) begin
            tick();
        end
    endtask

    // stores never overlap an outstanding fetch, so the model stays ordered
    task automatic randomTraffic(input int n);
        int issued;
        int gapData;
        int gapFetch;
        logic [31:0] r;
        logic [31:0] off;
        logic [31:0] wd;
        accessOp_e op;
        issued = 0;
        gapData = 0;
        gapFetch = 0;
        while (issued < n) begin
            if (!dataBusy && gapData > 0) begin
                gapData--;
            end else if (!dataBusy) begin
                takeBits(1, r);
                op = r[0] ? opStore : opLoad;
                if (!(op == opStore && fetchBusy)) begin
                    takeBits(2, r);
                    takeBits(6, off);
                    takeBits(32, wd);
                    issueData(op, (r == 0) ? lenByte : (r == 1) ? lenHalf : lenWord,
                              WIN_BASE + off, wd);
                    issued++;
                    takeBits(3, r);
                    gapData = int'(r);
                end
            end
            if (!fetchBusy && gapFetch > 0) begin
                gapFetch--;
            end else if (!fetchBusy && !(dataBusy && dataIsStore) && issued < n) begin
                takeBits(1, r);
                takeBits(6, off);
                issueFetch((r[0] ? ZERO_BASE : WIN_BASE) + off);
                issued++;
                takeBits(3, r);
                gapFetch = int'(r);
            end
            tick();
        end
        waitIdle();
    endtask

    initial begin
        logic [31:0] base;
        logic [31:0] off;
        logic [31:0] wd;
        accessLen_e len;
        rst = 1'b1;
        fetchReq = 1'b0;
        fetchAddr = '0;
        dataReq = 1'b0;
        dataIn = '0;
        pendStore = '0;
        ioBufferFull = 1'b0;
        fetchBusy = 1'b0;
        dataBusy = 1'b0;
        dataIsStore = 1'b0;
        orderCheck = 1'b0;
        finished = 1'b0;
        stallEnable = 1'b0;
        stallLeft = 0;
        expFetch = '0;
        expData = '0;
        latTarget = 0;
        testId = 0;
        lfsr = 32'hd5a80d6d;
        for (int i = 0; i < (1 << ADDR_W); i++) begin
            model[i] = 8'h00;
        end
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        testId = 1;
        repeat (5) tick();
        latTarget = 5;
        issueData(opStore, lenWord, WIN_BASE, 32'h1234_5678);
        waitIdle();
        latTarget = 6;
        issueData(opLoad, lenWord, WIN_BASE, '0);
        waitIdle();
        latTarget = 0;

        testId = 2;
        for (int l = 0; l < 3; l++) begin
            base = WIN_BASE + 32'(l * 8);
            len = (l == 0) ? lenByte : (l == 1) ? lenHalf : lenWord;
            issueData(opStore, lenWord, base, 32'hA5C3_5A3C);
            waitIdle();
            issueData(opStore, len, base, 32'h8192_E7F6 ^ 32'(l));
            waitIdle();
            issueData(opLoad, len, base, '0);
            waitIdle();
            issueData(opLoad, lenWord, base, '0);
            waitIdle();
        end

        testId = 3;
        issueFetch(WIN_BASE);
        waitIdle();
        issueFetch(WIN_BASE + 32'd9);
        waitIdle();
        issueFetch(ZERO_BASE);
        waitIdle();
        issueFetch(ZERO_BASE + 32'h7FF0);
        waitIdle();

        testId = 4;
        repeat (8) begin
            takeBits(6, off);
            takeBits(32, wd);
            issueData(opStore, lenWord, WIN_BASE + off, wd);
            waitIdle();
            orderCheck = 1'b1;
            issueData(opLoad, lenWord, WIN_BASE + off, '0);
            takeBits(6, off);
            issueFetch(WIN_BASE + off);
            waitIdle();
            orderCheck = 1'b0;
        end

        testId = 5;
        stallEnable = 1'b1;
        randomTraffic(STALL_REQ);
        stallEnable = 1'b0;
        while (ioBufferFull) begin
            tick();
        end

        testId = 6;
        randomTraffic(RAND_REQ);

        finished = 1'b1;
        tick();
        tick();
        if (errCount == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
common/memPkg.sv
src/reqArbiter.sv
memCtrl/memCtrl.sv
src/byteRam.sv
src/memSubsystem.sv
tb/memChecker.sv
tb/tbMemSubsystem.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the memory subsystem testbench with Verilator.
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f flist.f --top-module tbMemSubsystem -o simv
if [ $? -ne 0 ]; then
    echo "Verilator compile returned an error"
    exit 1
fi

./obj_dir/simv > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "tests failed" "$LOG"; then
    exit 1
fi
if ! grep -q "all tests passed" "$LOG"; then
    echo "simulation ended without a result line"
    exit 1
fi
exit 0
